//--- common/cpuPkg.sv
package cpuPkg;

    localparam int XLEN       = 32;
    localparam int IMEM_WORDS = 64;
    localparam int DMEM_WORDS = 64;

    typedef logic [XLEN-1:0] word_t;                    // Data or instruction word
    typedef logic [4:0]      regIdx_t;                  // x0 .. x31
    typedef logic [$clog2(IMEM_WORDS)-1:0] imemIdx_t;   // Instruction word index
    typedef logic [$clog2(DMEM_WORDS)-1:0] dmemIdx_t;   // Data word index

    // Major opcodes of the supported subset
    localparam logic [6:0] OPC_RTYPE = 7'b0110011;
    localparam logic [6:0] OPC_ITYPE = 7'b0010011;
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    // funct3 of register and immediate arithmetic
    localparam logic [2:0] F3_ADD  = 3'b000;            // Also sub
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;            // srl or sra by bit 30
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // funct3 of lw and sw
    localparam logic [2:0] F3_WORD = 3'b010;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND
    } aluOp_t;

endpackage

//--- hdl/instMem.sv
`timescale 1ns/1ps

module instMem (
    input  logic             CLK,
    input  logic             RST,
    input  logic             progWe,
    input  cpuPkg::imemIdx_t progAddr,
    input  cpuPkg::word_t    progData,
    input  cpuPkg::imemIdx_t addr,
    output cpuPkg::word_t    inst
);
    import cpuPkg::*;

    word_t mem [IMEM_WORDS];          // Program image, kept across reset

    // The program can only change while the core is held in reset
    always_ff @(posedge CLK) begin
        if (RST && progWe) begin
            mem[progAddr] <= progData;
        end
    end

    assign inst = mem[addr];          // Zero latency fetch

endmodule

//--- hdl/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic            CLK,
    input  logic            RST,
    input  cpuPkg::regIdx_t rs1,
    input  cpuPkg::regIdx_t rs2,
    input  cpuPkg::regIdx_t rd,
    input  cpuPkg::word_t   wd,
    input  logic            we,
    output cpuPkg::word_t   rd1,
    output cpuPkg::word_t   rd2
);
    import cpuPkg::*;

    localparam int NUM_REGS = 32;

    word_t regs [NUM_REGS];

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != '0)) begin     // x0 writes dropped
            regs[rd] <= wd;
        end
    end

    // Reads see the old value in the cycle of a write
    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- hdl/dataMem.sv
`timescale 1ns/1ps

module dataMem (
    input  logic             CLK,
    input  logic             RST,
    input  cpuPkg::dmemIdx_t addr,
    input  logic             we,
    input  cpuPkg::word_t    wd,
    output cpuPkg::word_t    rdata
);
    import cpuPkg::*;

    word_t mem [DMEM_WORDS];

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                mem[i] <= '0;               // Unwritten words read as zero
            end
        end else if (we) begin
            mem[addr] <= wd;
        end
    end

    assign rdata = mem[addr];               // Combinational load path

endmodule

//--- hdl/decoder.sv
`timescale 1ns/1ps

module decoder (
    input  cpuPkg::word_t  inst,
    output logic           regWrite,
    output logic           aluSrcImm,
    output logic           memRead,
    output logic           memWrite,
    output cpuPkg::aluOp_t aluOp,
    output cpuPkg::word_t  imm
);
    import cpuPkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;                        // Bit 30 selects sub and sra
    word_t      immI;
    word_t      immS;
    word_t      immShamt;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign alt    = inst[30];

    assign immI     = {{20{inst[31]}}, inst[31:20]};
    assign immS     = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign immShamt = {27'd0, inst[24:20]};

    // Shared by R-type and I-type, alt is already qualified by the caller
    function automatic aluOp_t opFromFunct3(input logic [2:0] f3, input logic useAlt);
        aluOp_t op;
        case (f3)
            F3_ADD:  op = useAlt ? SUB : ADD;
            F3_SLL:  op = SLL;
            F3_SLT:  op = SLT;
            F3_SLTU: op = SLTU;
            F3_XOR:  op = XOR;
            F3_SR:   op = useAlt ? SRA : SRL;
            F3_OR:   op = OR;
            F3_AND:  op = AND;
            default: op = ADD;
        endcase
        return op;
    endfunction

    always_comb begin
        regWrite  = 1'b0;                   // Unknown opcodes fall out as no-ops
        aluSrcImm = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        aluOp     = ADD;
        imm       = '0;
        case (opcode)
            OPC_RTYPE: begin
                regWrite = 1'b1;
                aluOp    = opFromFunct3(funct3, alt);
            end
            OPC_ITYPE: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                // No subi, so bit 30 only matters for srai
                aluOp = opFromFunct3(funct3, alt && (funct3 == F3_SR));
                if ((funct3 == F3_SLL) || (funct3 == F3_SR)) begin
                    imm = immShamt;
                end else begin
                    imm = immI;
                end
            end
            OPC_LOAD: begin
                if (funct3 == F3_WORD) begin    // lw only
                    regWrite  = 1'b1;
                    aluSrcImm = 1'b1;
                    memRead   = 1'b1;
                    imm       = immI;
                end
            end
            OPC_STORE: begin
                if (funct3 == F3_WORD) begin    // sw only
                    aluSrcImm = 1'b1;
                    memWrite  = 1'b1;
                    imm       = immS;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

//--- hdl/alu.sv
`timescale 1ns/1ps

module alu (
    input  cpuPkg::word_t  a,
    input  cpuPkg::word_t  b,
    input  cpuPkg::aluOp_t op,
    output cpuPkg::word_t  y
);
    import cpuPkg::*;

    logic [4:0] shamt;
    logic       ltSigned;
    logic       ltUnsigned;

    assign shamt      = b[4:0];             // Upper bits of b ignored for shifts
    assign ltSigned   = $signed(a) < $signed(b);
    assign ltUnsigned = a < b;

    always_comb begin
        case (op)
            ADD: begin
                y = a + b;
            end
            SUB: begin
                y = a - b;
            end
            SLL: begin
                y = a << shamt;
            end
            SLT: begin
                y = {31'd0, ltSigned};
            end
            SLTU: begin
                y = {31'd0, ltUnsigned};
            end
            XOR: begin
                y = a ^ b;
            end
            SRL: begin
                y = a >> shamt;
            end
            SRA: begin
                y = $unsigned($signed(a) >>> shamt);   // Sign bit fills from the left
            end
            OR: begin
                y = a | b;
            end
            AND: begin
                y = a & b;
            end
            default: begin
                y = '0;
            end
        endcase
    end

endmodule

//--- hdl/singleCpu.sv
`timescale 1ns/1ps

module singleCpu (
    input  logic             CLK,
    input  logic             RST,
    input  logic             progWe,
    input  cpuPkg::imemIdx_t progAddr,
    input  cpuPkg::word_t    progData,
    output cpuPkg::word_t    retPc,
    output logic             wbEn,
    output cpuPkg::regIdx_t  wbReg,
    output cpuPkg::word_t    wbData,
    output logic             stEn,
    output cpuPkg::word_t    stAddr,
    output cpuPkg::word_t    stData
);
    import cpuPkg::*;

    word_t    pc;
    imemIdx_t fetchIdx;
    word_t    inst;
    regIdx_t  rs1;
    regIdx_t  rs2;
    regIdx_t  rd;
    word_t    rd1;
    word_t    rd2;
    logic     regWrite;
    logic     aluSrcImm;
    logic     memRead;
    logic     memWrite;
    aluOp_t   aluOp;
    word_t    imm;
    word_t    aluB;
    word_t    aluY;
    dmemIdx_t dataIdx;
    word_t    memRdata;

    // No branches, so the next pc is always pc + 4
    always_ff @(posedge CLK) begin
        if (RST) begin
            pc <= '0;
        end else begin
            pc <= pc + 32'd4;
        end
    end

    assign fetchIdx = pc[7:2];              // Wraps after 64 words

    instMem uInstMem (
        .CLK     (CLK),
        .RST     (RST),
        .progWe  (progWe),
        .progAddr(progAddr),
        .progData(progData),
        .addr    (fetchIdx),
        .inst    (inst)
    );

    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];
    assign rd  = inst[11:7];

    decoder uDecoder (
        .inst     (inst),
        .regWrite (regWrite),
        .aluSrcImm(aluSrcImm),
        .memRead  (memRead),
        .memWrite (memWrite),
        .aluOp    (aluOp),
        .imm      (imm)
    );

    regFile uRegFile (
        .CLK(CLK),
        .RST(RST),
        .rs1(rs1),
        .rs2(rs2),
        .rd (rd),
        .wd (wbData),
        .we (regWrite),
        .rd1(rd1),
        .rd2(rd2)
    );

    assign aluB = aluSrcImm ? imm : rd2;

    alu uAlu (
        .a (rd1),
        .b (aluB),
        .op(aluOp),
        .y (aluY)
    );

    assign dataIdx = aluY[7:2];             // Low address bits dropped, no alignment check

    dataMem uDataMem (
        .CLK  (CLK),
        .RST  (RST),
        .addr (dataIdx),
        .we   (memWrite),
        .wd   (rd2),
        .rdata(memRdata)
    );

    assign wbData = memRead ? memRdata : aluY;

    // Retirement view of the instruction at pc, nothing retires while held in reset
    assign retPc  = pc;
    assign wbEn   = regWrite && (rd != '0) && !RST;
    assign wbReg  = rd;
    assign stEn   = memWrite && !RST;
    assign stAddr = aluY;
    assign stData = rd2;

endmodule

//--- dv/isaModel.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// Architectural state of the reference model
word_t mRegs [32];                  // x0 is never written, so it stays zero
word_t mDmem [64];
word_t mPc;

// Expected retirement of the instruction last given to stepModel
logic    expWbEn;
regIdx_t expWbReg;
word_t   expWbData;
logic    expStEn;
word_t   expStAddr;
word_t   expStData;

task automatic clearModel();
    for (int i = 0; i < 32; i++) begin
        mRegs[i] = '0;
    end
    for (int i = 0; i < 64; i++) begin
        mDmem[i] = '0;              // Matches the cleared data RAM
    end
    mPc = '0;
endtask

function automatic word_t signExt12(input logic [11:0] v);
    return {{20{v[11]}}, v};
endfunction

// Integer result by funct3, alt selects sub or sra
function automatic word_t intOp(input logic [2:0] f3, input logic alt,
                                input word_t a, input word_t b);
    logic [4:0] sh;
    word_t      fill;
    sh   = b[4:0];
    fill = a[31] ? ~(32'hFFFF_FFFF >> sh) : 32'd0;    // Upper bits set for sra
    case (f3)
        F3_ADD:  return alt ? (a - b) : (a + b);
        F3_SLL:  return a << sh;
        F3_SLT:  return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
        F3_SLTU: return {31'd0, a < b};
        F3_XOR:  return a ^ b;
        F3_SR:   return alt ? ((a >> sh) | fill) : (a >> sh);
        F3_OR:   return a | b;
        F3_AND:  return a & b;
        default: return '0;
    endcase
endfunction

task automatic writeReg(input regIdx_t rd, input word_t value);
    if (rd != 5'd0) begin
        mRegs[rd] = value;
        expWbEn   = 1'b1;
        expWbData = value;
    end
endtask

// Executes one instruction and records what the core should retire
task automatic stepModel(input word_t inst);
    logic [6:0] opc;
    logic [2:0] f3;
    regIdx_t    rs1;
    regIdx_t    rs2;
    regIdx_t    rd;
    word_t      a;
    word_t      b;
    word_t      ea;
    logic       isShift;
    opc       = inst[6:0];
    f3        = inst[14:12];
    rs1       = inst[19:15];
    rs2       = inst[24:20];
    rd        = inst[11:7];
    a         = mRegs[rs1];
    b         = mRegs[rs2];
    isShift   = (f3 == F3_SLL) || (f3 == F3_SR);
    expWbEn   = 1'b0;
    expWbReg  = rd;
    expWbData = '0;
    expStEn   = 1'b0;
    expStAddr = '0;
    expStData = '0;
    case (opc)
        OPC_RTYPE: begin
            writeReg(rd, intOp(f3, inst[30], a, b));
        end
        OPC_ITYPE: begin
            if (isShift) begin
                writeReg(rd, intOp(f3, inst[30] && (f3 == F3_SR), a, {27'd0, inst[24:20]}));
            end else begin
                writeReg(rd, intOp(f3, 1'b0, a, signExt12(inst[31:20])));
            end
        end
        OPC_LOAD: begin
            if (f3 == F3_WORD) begin
                ea = a + signExt12(inst[31:20]);
                writeReg(rd, mDmem[ea[7:2]]);   // Low address bits ignored
            end
        end
        OPC_STORE: begin
            if (f3 == F3_WORD) begin
                ea        = a + signExt12({inst[31:25], inst[11:7]});
                expStEn   = 1'b1;
                expStAddr = ea;
                expStData = b;
                mDmem[ea[7:2]] = b;
            end
        end
        default: begin
        end
    endcase
    mPc = mPc + 32'd4;
endtask

`endif

//--- dv/singleCpuTb.sv
`timescale 1ns/1ps

module singleCpuTb;
    import cpuPkg::*;

    localparam int SEED          = 93082;
    localparam int PROG_LEN      = 48;
    localparam int CYCLE_TIMEOUT = 200;
    localparam int CLK_PERIOD    = 8;
    localparam int RESET_CYCLES  = 5;
    localparam int SETTLE        = 1;     // Sample point after the falling edge

    logic     CLK = 1'b0;                 // Starts low without an edge at time 0
    logic     RST;
    logic     progWe;
    imemIdx_t progAddr;
    word_t    progData;
    word_t    retPc;
    logic     wbEn;
    regIdx_t  wbReg;
    word_t    wbData;
    logic     stEn;
    word_t    stAddr;
    word_t    stData;

    word_t    prog [IMEM_WORDS];          // Copy of the loaded program
    word_t    lastPc;
    int       retired;
    int       cycles;

    `include "isaModel.svh"

    singleCpu UUT (
        .CLK     (CLK),
        .RST     (RST),
        .progWe  (progWe),
        .progAddr(progAddr),
        .progData(progData),
        .retPc   (retPc),
        .wbEn    (wbEn),
        .wbReg   (wbReg),
        .wbData  (wbData),
        .stEn    (stEn),
        .stAddr  (stAddr),
        .stData  (stData)
    );

    initial begin
        forever begin
            #(CLK_PERIOD / 2) CLK = ~CLK;
        end
    end

    task automatic check(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("FAIL at %0t: %s expected %h actual %h", $time, name, expected, actual);
            $display("** FAIL **");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Nothing may retire while the core is held in reset
    task automatic expectIdle();
        check("retPc", 32'd0, retPc);
        check("wbEn", 32'd0, {31'd0, wbEn});
        check("stEn", 32'd0, {31'd0, stEn});
    endtask

    task automatic compareRetirement();
        check("retPc", mPc, retPc);
        stepModel(prog[mPc[7:2]]);
        check("wbEn", {31'd0, expWbEn}, {31'd0, wbEn});
        if (expWbEn) begin
            check("wbReg", {27'd0, expWbReg}, {27'd0, wbReg});
            check("wbData", expWbData, wbData);
        end
        check("stEn", {31'd0, expStEn}, {31'd0, stEn});
        if (expStEn) begin
            check("stAddr", expStAddr, stAddr);
            check("stData", expStData, stData);
        end
    endtask

    function automatic regIdx_t randomReg();
        word_t r;
        r = $urandom;
        return {2'b00, r[2:0]};           // x0 .. x7 so results get reused
    endfunction

    function automatic word_t noopWord();
        word_t w;
        w = $urandom;
        w[1:0] = 2'b01;                   // Every supported opcode ends in 11
        return w;
    endfunction

    function automatic logic [11:0] memOffset();
        word_t r;
        r = $urandom;
        return {7'd0, r[2:0], 2'b00};     // Few words, so loads hit earlier stores
    endfunction

    function automatic word_t randomInst(input int idx);
        word_t       r;
        word_t       kind;
        logic [2:0]  f3;
        logic [6:0]  funct7;
        logic [11:0] imm12;
        logic [11:0] off;
        regIdx_t     rs1;
        regIdx_t     rs2;
        regIdx_t     rd;
        regIdx_t     base;
        r      = $urandom;
        kind   = $urandom % 16;
        f3     = r[2:0];
        funct7 = r[3] ? 7'b0100000 : 7'b0000000;
        imm12  = r[31:20];
        rs1    = randomReg();
        rs2    = randomReg();
        rd     = randomReg();
        off    = memOffset();
        base   = r[4] ? randomReg() : 5'd0;
        if (idx < 7) begin
            // Seed x1 .. x7 with addi from x0
            return {imm12, 5'd0, F3_ADD, regIdx_t'(idx + 1), OPC_ITYPE};
        end else if (kind < 6) begin
            return {funct7, rs2, rs1, f3, rd, OPC_RTYPE};
        end else if (kind < 10) begin
            if ((f3 == F3_SLL) || (f3 == F3_SR)) begin
                imm12 = {funct7, r[24:20]};   // Shift amount, bit 30 picks srai
            end
            return {imm12, rs1, f3, rd, OPC_ITYPE};
        end else if (kind < 12) begin
            return {off, base, F3_WORD, rd, OPC_LOAD};
        end else if (kind < 14) begin
            return {off[11:5], rs2, base, F3_WORD, off[4:0], OPC_STORE};
        end else if (kind < 15) begin
            return {imm12, rs1, F3_ADD, 5'd0, OPC_ITYPE};
        end else begin
            return noopWord();
        end
    endfunction

    initial begin
        RST      = 1'b1;
        progWe   = 1'b0;
        progAddr = '0;
        progData = '0;
        void'($urandom(SEED));
        for (int i = 0; i < IMEM_WORDS; i++) begin
            prog[i] = (i < PROG_LEN) ? randomInst(i) : noopWord();
        end
        clearModel();

        // One word per clock, only accepted while RST is high
        for (int i = 0; i < IMEM_WORDS; i++) begin
            @(negedge CLK);
            progWe   = 1'b1;
            progAddr = imemIdx_t'(i);
            progData = prog[i];
            #(SETTLE);
            expectIdle();
        end
        @(negedge CLK);
        progWe = 1'b0;
        repeat (RESET_CYCLES) begin
            @(negedge CLK);
            #(SETTLE);
            expectIdle();
        end
        @(negedge CLK);
        RST = 1'b0;
        #(SETTLE);

        lastPc  = 32'hFFFF_FFFF;
        retired = 0;
        cycles  = 0;
        while ((retired < PROG_LEN) && (cycles < CYCLE_TIMEOUT)) begin
            if (retPc !== lastPc) begin   // A new pc means a new instruction
                lastPc = retPc;
                compareRetirement();
                retired++;
            end
            cycles++;
            @(negedge CLK);
            #(SETTLE);
        end

        if (retired < PROG_LEN) begin
            $display("The core stopped retiring after %0d of %0d instructions",
                     retired, PROG_LEN);
            $display("** FAIL **");
            $fatal(1, "Retirement timeout");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

//--- project.f
+incdir+dv
common/cpuPkg.sv
hdl/instMem.sv
hdl/regFile.sv
hdl/dataMem.sv
hdl/decoder.sv
hdl/alu.sv
hdl/singleCpu.sv
dv/singleCpuTb.sv

//--- run.sh
#!/bin/sh
# Build and run the single cycle core testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --top-module singleCpuTb -f project.f -Mdir "$BUILD_DIR" -o simv
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/simv" > "$LOG" 2>&1
simStatus=$?
cat "$LOG"

if grep -qF '** FAIL **' "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi

if [ "$simStatus" -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

echo "Simulation finished without failures"
exit 0
